/* design/BlendPkg.sv */
// ******************
// Shared types, widths and blend-factor codes for the alpha-blending stage
// ******************

`default_nettype none

package BlendPkg;

    // Bits per color channel. The 1.0 normalization in the mixer only holds for 8
    localparam int ChannelWidth = 8;
    localparam int NumChannels = 4;

    // A weight gains one bit so that 255 can be promoted to 256
    localparam int WeightWidth = ChannelWidth + 1;
    localparam int ProductWidth = WeightWidth + ChannelWidth;
    localparam int SumWidth = ProductWidth + 1;

    // Cycles from operand sampling to a registered mixer result
    localparam int MixerLatency = 2;

    localparam int FactorWidth = 4;

    typedef logic [ChannelWidth-1:0] channel_t;
    typedef logic [FactorWidth-1:0] factor_t;

    // Red sits in the most significant byte
    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
        channel_t a;
    } rgba_t;

    typedef struct packed {
        factor_t srcFactor;
        factor_t dstFactor;
    } blendCfg_t;

    // Blend-factor codes. Codes 11 to 15 are unused and act as zero
    localparam factor_t FactorZero             = 4'd0;
    localparam factor_t FactorOne              = 4'd1;
    localparam factor_t FactorDstColor         = 4'd2;
    localparam factor_t FactorSrcColor         = 4'd3;
    localparam factor_t FactorOneMinusDstColor = 4'd4;
    localparam factor_t FactorOneMinusSrcColor = 4'd5;
    localparam factor_t FactorSrcAlpha         = 4'd6;
    localparam factor_t FactorOneMinusSrcAlpha = 4'd7;
    localparam factor_t FactorDstAlpha         = 4'd8;
    localparam factor_t FactorOneMinusDstAlpha = 4'd9;
    localparam factor_t FactorSrcAlphaSaturate = 4'd10;

    // All ones stands for 1.0
    localparam channel_t OnePointZero = '1;

    // Source passes straight through after reset
    localparam blendCfg_t CfgReset = '{
        srcFactor: FactorOne,
        dstFactor: FactorZero
    };

endpackage

`default_nettype wire

/* design/ColorMixer.sv */
// ******************
// Two-stage four-channel mixer computing A*B + C*D with 1.0 normalization
// ******************

`default_nettype none
`timescale 1ns/1ps

module ColorMixer
(
    input  logic            aclk,
    input  logic            rst,

    input  BlendPkg::rgba_t colorA,
    input  BlendPkg::rgba_t colorB,
    input  BlendPkg::rgba_t colorC,
    input  BlendPkg::rgba_t colorD,

    output BlendPkg::rgba_t mixedColor
);
    import BlendPkg::*;

    // Channel views of the operands, index 3 is red and index 0 is alpha
    channel_t [NumChannels-1:0] chA;
    channel_t [NumChannels-1:0] chB;
    channel_t [NumChannels-1:0] chC;
    channel_t [NumChannels-1:0] chD;
    channel_t [NumChannels-1:0] mixedCh;

    // Adding the weight's top bit maps 255 to 256, so a full weight
    // survives the final shift by 8 unchanged
    function automatic logic [WeightWidth-1:0] adjustWeight(input channel_t weight);
        return {1'b0, weight} + WeightWidth'(weight[ChannelWidth-1]);
    endfunction

    assign chA = colorA;
    assign chB = colorB;
    assign chC = colorC;
    assign chD = colorD;

    for (genvar i = 0; i < NumChannels; i++)
    begin : genChannel
        logic [ProductWidth-1:0] productSrc;
        logic [ProductWidth-1:0] productDst;
        logic [SumWidth-1:0]     sum;
        logic [SumWidth-ChannelWidth-1:0] scaled;
        channel_t                clamped;
        channel_t                mixed;

        // Stage two arithmetic, working on the registered products
        assign sum = {1'b0, productSrc} + {1'b0, productDst};
        assign scaled = sum[SumWidth-1:ChannelWidth];

        // Anything above the channel range saturates to 1.0
        assign clamped = (|scaled[SumWidth-ChannelWidth-1:ChannelWidth])
                         ? OnePointZero
                         : scaled[ChannelWidth-1:0];

        always_ff @(posedge aclk)
        begin
            if (rst)
            begin
                productSrc <= '0;
                productDst <= '0;
                mixed <= '0;
            end
            else
            begin
                productSrc <= ProductWidth'(adjustWeight(chA[i])) * ProductWidth'(chB[i]);
                productDst <= ProductWidth'(adjustWeight(chC[i])) * ProductWidth'(chD[i]);
                mixed <= clamped;
            end
        end

        assign mixedCh[i] = mixed;
    end

    assign mixedColor = mixedCh;

endmodule

`default_nettype wire

/* design/ColorBlender.sv */
// ******************
// Blend-factor selection for source and destination, feeding the color mixer
// ******************

`default_nettype none
`timescale 1ns/1ps

module ColorBlender
(
    input  logic                aclk,
    input  logic                rst,

    input  BlendPkg::blendCfg_t cfg,

    input  BlendPkg::rgba_t     sourceColor,
    input  BlendPkg::rgba_t     destColor,

    output BlendPkg::rgba_t     color
);
    import BlendPkg::*;

    // Per-channel weights handed to the mixer
    rgba_t srcWeight;
    rgba_t dstWeight;

    // Alpha terms shared between both factor decoders
    channel_t srcAlpha;
    channel_t dstAlpha;
    channel_t srcAlphaInv;
    channel_t dstAlphaInv;
    channel_t satAlpha;

    // Same value on every channel, used by the alpha and constant factors
    function automatic rgba_t splat(input channel_t value);
        rgba_t result;

        result.r = value;
        result.g = value;
        result.b = value;
        result.a = value;
        return result;
    endfunction

    // Channel-wise one minus the color
    function automatic rgba_t invert(input rgba_t value);
        rgba_t result;

        result.r = OnePointZero - value.r;
        result.g = OnePointZero - value.g;
        result.b = OnePointZero - value.b;
        result.a = OnePointZero - value.a;
        return result;
    endfunction

    assign srcAlpha = sourceColor.a;
    assign dstAlpha = destColor.a;
    assign srcAlphaInv = OnePointZero - srcAlpha;
    assign dstAlphaInv = OnePointZero - dstAlpha;

    // Smaller of source alpha and the free coverage left in the destination
    assign satAlpha = (srcAlpha < dstAlphaInv) ? srcAlpha : dstAlphaInv;

    // Source side. Source color factors make no sense here and fall to zero
    always_comb
    begin
        case (cfg.srcFactor)
            FactorZero:
                srcWeight = '0;
            FactorOne:
                srcWeight = splat(OnePointZero);
            FactorDstColor:
                srcWeight = destColor;
            FactorOneMinusDstColor:
                srcWeight = invert(destColor);
            FactorSrcAlpha:
                srcWeight = splat(srcAlpha);
            FactorOneMinusSrcAlpha:
                srcWeight = splat(srcAlphaInv);
            FactorDstAlpha:
                srcWeight = splat(dstAlpha);
            FactorOneMinusDstAlpha:
                srcWeight = splat(dstAlphaInv);
            FactorSrcAlphaSaturate:
            begin
                // Alpha itself is always weighted by a full 1.0
                srcWeight = splat(satAlpha);
                srcWeight.a = OnePointZero;
            end
            default:
                srcWeight = '0;
        endcase
    end

    // Destination side. Destination color factors and saturate are not
    // legal here and act as zero
    always_comb
    begin
        case (cfg.dstFactor)
            FactorZero:
                dstWeight = '0;
            FactorOne:
                dstWeight = splat(OnePointZero);
            FactorSrcColor:
                dstWeight = sourceColor;
            FactorOneMinusSrcColor:
                dstWeight = invert(sourceColor);
            FactorSrcAlpha:
                dstWeight = splat(srcAlpha);
            FactorOneMinusSrcAlpha:
                dstWeight = splat(srcAlphaInv);
            FactorDstAlpha:
                dstWeight = splat(dstAlpha);
            FactorOneMinusDstAlpha:
                dstWeight = splat(dstAlphaInv);
            default:
                dstWeight = '0;
        endcase
    end

    // The mixer registers its operands on the next edge, so selection
    // stays purely combinational and the blender latency equals the mixer's
    ColorMixer colorMixer_i
    (
        .aclk       (aclk),
        .rst        (rst),

        .colorA     (srcWeight),
        .colorB     (sourceColor),
        .colorC     (dstWeight),
        .colorD     (destColor),

        .mixedColor (color)
    );

endmodule

`default_nettype wire

/* design/BlendStage.sv */
// ******************
// Alpha-blending stage top level with config register and valid tracking
// ******************

`default_nettype none
`timescale 1ns/1ps

module BlendStage
(
    input  logic                aclk,
    input  logic                rst,

    // Blend configuration write
    input  logic                cfgWrite,
    input  BlendPkg::blendCfg_t cfg,

    // Incoming pixel with fragment and framebuffer colors
    input  logic                pixelValid,
    input  BlendPkg::rgba_t     srcColor,
    input  BlendPkg::rgba_t     dstColor,

    // Blended result, two cycles behind its pixel
    output logic                colorValid,
    output BlendPkg::rgba_t     color
);
    import BlendPkg::*;

    blendCfg_t cfgReg;

    // Bit 0 is the newest pixel, the top bit lines up with the mixer output
    logic [MixerLatency-1:0] validPipe;

    // A write lands on the edge that ends its cycle. A pixel in that same
    // cycle was already decoded with the old value
    always_ff @(posedge aclk)
    begin
        if (rst)
            cfgReg <= CfgReset;
        else if (cfgWrite)
            cfgReg <= cfg;
    end

    always_ff @(posedge aclk)
    begin
        if (rst)
            validPipe <= '0;
        else
            validPipe <= {validPipe[MixerLatency-2:0], pixelValid};
    end

    assign colorValid = validPipe[MixerLatency-1];

    // Color runs free through the pipeline, only colorValid qualifies it
    ColorBlender colorBlender_i
    (
        .aclk        (aclk),
        .rst         (rst),

        .cfg         (cfgReg),

        .sourceColor (srcColor),
        .destColor   (dstColor),

        .color       (color)
    );

endmodule

`default_nettype wire

/* test/BlendStage_sva.sv */
// ********************
// Assertions on valid timing and reset of the blend stage
// ********************

`default_nettype none
`timescale 1ns/1ps

module BlendStageSva
(
    input logic            aclk,
    input logic            rst,
    input logic            pixelValid,
    input logic            colorValid,
    input BlendPkg::rgba_t color
);

    // Only once the whole delay line has left reset
    validDelay: assert property (@(posedge aclk)
        (!rst && !$past(rst) && !$past(rst, 2)) |-> colorValid == $past(pixelValid, 2))
    else
        $error("colorValid does not follow pixelValid by two cycles");

    resetClearsValid: assert property (@(posedge aclk) rst |=> !colorValid)
    else
        $error("colorValid high right after reset");

    colorKnown: assert property (@(posedge aclk) colorValid |-> !$isunknown(color))
    else
        $error("color unknown while colorValid is high");

endmodule

bind BlendStage BlendStageSva blendStageSva_i
(
    .aclk       (aclk),
    .rst        (rst),
    .pixelValid (pixelValid),
    .colorValid (colorValid),
    .color      (color)
);

`default_nettype wire

/* test/BlendStageTb.sv */
// ********************
// Testbench for the blend stage: random pixels and configs checked
// against a reference model, with results matched in order
// ********************

`default_nettype none
`timescale 1ns/1ps

module BlendStageTb;
    import BlendPkg::*;

    logic      aclk;
    logic      rst;
    logic      cfgWrite;
    blendCfg_t cfg;
    logic      pixelValid;
    rgba_t     srcColor;
    rgba_t     dstColor;
    logic      colorValid;
    rgba_t     color;

    integer    seed;
    blendCfg_t modelCfg;
    rgba_t     expectQ [$];

    // Bit 0 is the pixelValid driven last cycle, bit 1 the one before
    logic [1:0] validHist;

    BlendStage dut_i
    (
        .aclk       (aclk),
        .rst        (rst),
        .cfgWrite   (cfgWrite),
        .cfg        (cfg),
        .pixelValid (pixelValid),
        .srcColor   (srcColor),
        .dstColor   (dstColor),
        .colorValid (colorValid),
        .color      (color)
    );

    initial
    begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // Weight for one channel of one side, straight from the factor table
    function automatic int pickWeight(input factor_t code, input bit isSource,
                                      input int srcCh, input int dstCh,
                                      input int srcA, input int dstA, input bit isAlpha);
        int w;

        case (code)
            FactorZero:             w = 0;
            FactorOne:              w = 255;
            FactorDstColor:         w = isSource ? dstCh : 0;
            FactorOneMinusDstColor: w = isSource ? 255 - dstCh : 0;
            FactorSrcColor:         w = isSource ? 0 : srcCh;
            FactorOneMinusSrcColor: w = isSource ? 0 : 255 - srcCh;
            FactorSrcAlpha:         w = srcA;
            FactorOneMinusSrcAlpha: w = 255 - srcA;
            FactorDstAlpha:         w = dstA;
            FactorOneMinusDstAlpha: w = 255 - dstA;
            FactorSrcAlphaSaturate:
            begin
                if (!isSource)
                    w = 0;
                else if (isAlpha)
                    w = 255;
                else
                    w = (srcA < 255 - dstA) ? srcA : 255 - dstA;
            end
            default:                w = 0;
        endcase
        return w;
    endfunction

    // A full weight of 255 counts as 256 so that 1.0 times c gives back c
    function automatic channel_t blendChannel(input int ws, input int cs,
                                              input int wd, input int cd);
        int total;

        total = ((ws + ws / 128) * cs + (wd + wd / 128) * cd) / 256;
        if (total > 255)
            total = 255;
        return channel_t'(total);
    endfunction

    function automatic rgba_t expectedColor(input blendCfg_t c, input rgba_t s, input rgba_t d);
        int       sa [4];
        int       da [4];
        channel_t outCh [4];
        rgba_t    result;
        int       ws;
        int       wd;

        sa[0] = int'(s.r);
        sa[1] = int'(s.g);
        sa[2] = int'(s.b);
        sa[3] = int'(s.a);
        da[0] = int'(d.r);
        da[1] = int'(d.g);
        da[2] = int'(d.b);
        da[3] = int'(d.a);
        for (int i = 0; i < 4; i++)
        begin
            ws = pickWeight(c.srcFactor, 1'b1, sa[i], da[i], sa[3], da[3], i == 3);
            wd = pickWeight(c.dstFactor, 1'b0, sa[i], da[i], sa[3], da[3], i == 3);
            outCh[i] = blendChannel(ws, sa[i], wd, da[i]);
        end
        result.r = outCh[0];
        result.g = outCh[1];
        result.b = outCh[2];
        result.a = outCh[3];
        return result;
    endfunction

    function automatic rgba_t randomColor();
        return rgba_t'($random(seed));
    endfunction

    function automatic blendCfg_t randomCfg();
        logic [31:0] bits;

        bits = $random(seed);
        return bits[7:0];
    endfunction

    function automatic logic randomValid();
        return ($random(seed) & 3) != 0;
    endfunction

    task automatic abortRun();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkColor(input rgba_t expected, input rgba_t actual);
        if (actual !== expected)
        begin
            $display("FAIL time=%0t signal=color expected=%h actual=%h",
                     $time, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkValid(input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("FAIL time=%0t signal=colorValid expected=%b actual=%b",
                     $time, expected, actual);
            abortRun();
        end
    endtask

    // Outputs settled on the rising edge, so the falling edge sees them stable
    task automatic checkOutputs();
        checkValid(validHist[1], colorValid);
        if (colorValid)
        begin
            if (expectQ.size() == 0)
            begin
                $display("colorValid went high at %0t with no pixel outstanding", $time);
                abortRun();
            end
            else
                checkColor(expectQ.pop_front(), color);
        end
    endtask

    // One clock of stimulus. The pixel sees the config from before this write
    task automatic driveCycle(input logic valid, input logic write, input blendCfg_t newCfg,
                              input rgba_t src, input rgba_t dst);
        @(negedge aclk);
        checkOutputs();
        pixelValid = valid;
        cfgWrite = write;
        cfg = newCfg;
        srcColor = src;
        dstColor = dst;
        if (valid)
            expectQ.push_back(expectedColor(modelCfg, src, dst));
        if (write)
            modelCfg = newCfg;
        validHist = {validHist[0], valid};
    endtask

    task automatic driveIdle();
        driveCycle(1'b0, 1'b0, randomCfg(), randomColor(), randomColor());
    endtask

    initial
    begin
        blendCfg_t pairCfg;
        int        drainCount;

        seed = 32'he7d9;
        rst = 1'b1;
        cfgWrite = 1'b0;
        cfg = '0;
        pixelValid = 1'b0;
        srcColor = '0;
        dstColor = '0;
        validHist = '0;
        modelCfg = CfgReset;

        for (int i = 0; i < 16; i++)
            driveIdle();
        rst = 1'b0;

        // Reset config passes the source color straight through
        for (int i = 0; i < 40; i++)
            driveCycle(randomValid(), 1'b0, randomCfg(), randomColor(), randomColor());

        // Every code pair, legal or not, each followed by a back-to-back burst.
        // The first pixel has large channels to push the sum into saturation
        for (int s = 0; s < 16; s++)
        begin
            for (int d = 0; d < 16; d++)
            begin
                pairCfg.srcFactor = factor_t'(s);
                pairCfg.dstFactor = factor_t'(d);
                driveCycle(1'b0, 1'b1, pairCfg, randomColor(), randomColor());
                driveCycle(1'b1, 1'b0, randomCfg(), randomColor() | 32'h80808080,
                           randomColor() | 32'h80808080);
                for (int k = 0; k < 3; k++)
                    driveCycle(1'b1, 1'b0, randomCfg(), randomColor(), randomColor());
            end
        end

        // A write alongside a pixel only reaches the pixel after it
        for (int i = 0; i < 32; i++)
        begin
            driveCycle(1'b1, 1'b1, randomCfg(), randomColor(), randomColor());
            driveCycle(1'b1, 1'b0, randomCfg(), randomColor(), randomColor());
        end

        // Random gaps with the odd config change mixed in
        for (int i = 0; i < 300; i++)
            driveCycle(randomValid(), ($random(seed) & 15) == 0, randomCfg(),
                       randomColor(), randomColor());

        drainCount = 0;
        while (expectQ.size() > 0 && drainCount < 20)
        begin
            driveIdle();
            drainCount++;
        end

        if (expectQ.size() > 0)
        begin
            $display("Timed out waiting for %0d outstanding results", expectQ.size());
            abortRun();
        end
        else
        begin
            // A few quiet cycles to catch any stray colorValid
            for (int i = 0; i < 4; i++)
                driveIdle();
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb.f */
design/BlendPkg.sv
design/ColorMixer.sv
design/ColorBlender.sv
design/BlendStage.sv
test/BlendStage_sva.sv
test/BlendStageTb.sv

/* run.sh */
#!/bin/sh
# Build and run the blend stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module BlendStageTb -f tb.f -o BlendStageSim || exit 1

output=$(./obj_dir/BlendStageSim)
echo "$output"

echo "$output" | grep -qF "*** TEST PASSED ***" && exit 0 || exit 1
